/* common/vision_config.svh */
// vision config: component widths, conversion coefficients, hue sectors, class thresholds
`ifndef VISION_CONFIG_SVH
`define VISION_CONFIG_SVH

// ------------------------------------------------
// pixel format
// ------------------------------------------------
`define PIX_W       8     // bits per color component

// ycbcr -> rgb, 8 fraction bits
`define COEF_Y      298   // 1.164
`define COEF_CR_R   408   // 1.596
`define COEF_CR_G   208   // 0.813
`define COEF_CB_G   100   // 0.392
`define COEF_CB_B   516   // 2.017
`define LUMA_OFS    16
`define CHROMA_OFS  128

// ------------------------------------------------
// hue circle, 240 steps
// ------------------------------------------------
`define HUE_SECTOR  40    // one sixth of the circle
`define HUE_G_BASE  80    // green max offset
`define HUE_B_BASE  160   // blue max offset
`define HUE_FULL    240   // wrap point for red max

// classification windows, centre +/- tolerance
`define HUE_TOL     20
`define HUE_RED     220
`define HUE_ORANGE  20
`define HUE_YELLOW  40
`define HUE_GREEN   85
`define HUE_BLUE    148
`define SAT_HIGH    96    // strong chroma, also black limit
`define SAT_LOW     36    // weak chroma
`define SAT_SPOT    24    // spot detection
`define VAL_DARK    96    // below this counts as dark

`endif

/* common/video_pkg.sv */
// video sample formats: ycbcr, rgb888 and hsv pixels passed along the pipeline
`include "vision_config.svh"

package video_pkg;

	// ------------------------------------------------
	// one full 4:4:4 sample out of the 4:2:2 stream
	// ------------------------------------------------
	typedef struct packed {
		logic [`PIX_W-1:0] y;  // luma
		logic [`PIX_W-1:0] cb; // blue difference, shared by the pair
		logic [`PIX_W-1:0] cr; // red difference, shared by the pair
	} ycbcr_pixel_t;

	// clamped rgb888
	typedef struct packed {
		logic [`PIX_W-1:0] r;
		logic [`PIX_W-1:0] g;
		logic [`PIX_W-1:0] b;
	} rgb_pixel_t;

	// ------------------------------------------------
	// hsv with 240 step hue
	// ------------------------------------------------
	typedef struct packed {
		logic [`PIX_W-1:0] h; // 0..239
		logic [`PIX_W-1:0] s; // 0..255
		logic [`PIX_W-1:0] v; // max component
	} hsv_pixel_t;

endpackage

/* common/class_pkg.sv */
// classification results: per pixel color flags of the binarizer

package class_pkg;

	// ------------------------------------------------
	// seven flags, msb first
	// ------------------------------------------------
	typedef struct packed {
		logic spot;   // red or yellow, weak saturation allowed
		logic red;
		logic orange;
		logic yellow; // needs high chroma
		logic green;
		logic blue;
		logic black;  // dark and unsaturated
	} color_flags_t;

endpackage

/* verilog/ycbcr_capture.sv */
// ycbcr capture: sequences the Cb/Y0/Cr/Y1 byte stream into two full ycbcr pixels
`timescale 1ns/1ps
`include "vision_config.svh"

module ycbcr_capture (
	input  logic                      clk_llc,
	input  logic                      resetx,
	input  logic                      vref,       // frame level
	input  logic                      href,       // line level
	input  logic [`PIX_W-1:0]         video_byte,
	output logic                      ycc_valid,
	output video_pkg::ycbcr_pixel_t   ycc_pixel
);

	localparam logic [1:0] ph_cb = 2'd0;
	localparam logic [1:0] ph_y0 = 2'd1;
	localparam logic [1:0] ph_cr = 2'd2;
	localparam logic [1:0] ph_y1 = 2'd3;

	logic              take;     // byte accepted this edge
	logic [1:0]        phase;    // position inside the quad
	logic [`PIX_W-1:0] cb_q;
	logic [`PIX_W-1:0] y0_q;
	logic [`PIX_W-1:0] cr_q;
	logic [`PIX_W-1:0] y1_q;     // held for second pixel
	logic              y1_pend;  // second pixel due next edge

	assign take = vref & href;

	// ------------------------------------------------
	// phase sequencer, restarts at Cb on blanking
	// ------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			phase   <= ph_cb;
			y1_pend <= 1'b0;
		end
		else
		begin
			if (take)
				phase <= phase + 2'd1;
			else
				phase <= ph_cb; // partial quad dropped
			y1_pend <= take && (phase == ph_y1);
		end
	end

	// byte latches
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			cb_q <= '0;
			y0_q <= '0;
			cr_q <= '0;
			y1_q <= '0;
		end
		else if (take)
		begin
			case (phase)
				ph_cb:   cb_q <= video_byte;
				ph_y0:   y0_q <= video_byte;
				ph_cr:   cr_q <= video_byte;
				default: y1_q <= video_byte;
			endcase
		end
	end

	// ------------------------------------------------
	// output, Y0 pixel then Y1 pixel on back to back cycles
	// ------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			ycc_valid <= 1'b0;
			ycc_pixel <= '0;
		end
		else if (y1_pend)
		begin
			ycc_valid    <= 1'b1;
			ycc_pixel.y  <= y1_q; // chroma still from this quad
			ycc_pixel.cb <= cb_q;
			ycc_pixel.cr <= cr_q;
		end
		else if (take && (phase == ph_y1))
		begin
			ycc_valid    <= 1'b1;
			ycc_pixel.y  <= y0_q;
			ycc_pixel.cb <= cb_q;
			ycc_pixel.cr <= cr_q;
		end
		else
			ycc_valid <= 1'b0;
	end

endmodule

/* color_convert/ycbcr_to_rgb.sv */
// ycbcr to rgb888: two stage fixed point conversion with clamp to 0..255
`timescale 1ns/1ps
`include "vision_config.svh"

module ycbcr_to_rgb (
	input  logic                     clk_llc,
	input  logic                     resetx,
	input  logic                     ycc_valid,
	input  video_pkg::ycbcr_pixel_t  ycc_pixel,
	output logic                     rgb_valid,
	output video_pkg::rgb_pixel_t    rgb_pixel
);

	localparam int ofs_w  = `PIX_W + 2; // offset removed, signed
	localparam int prod_w = 20;         // holds 516 * -128 and sums

	localparam logic signed [11:0] coef_y    = `COEF_Y;
	localparam logic signed [11:0] coef_cr_r = `COEF_CR_R;
	localparam logic signed [11:0] coef_cr_g = `COEF_CR_G;
	localparam logic signed [11:0] coef_cb_g = `COEF_CB_G;
	localparam logic signed [11:0] coef_cb_b = `COEF_CB_B;
	localparam logic signed [ofs_w-1:0] luma_ofs   = `LUMA_OFS;
	localparam logic signed [ofs_w-1:0] chroma_ofs = `CHROMA_OFS;

	logic signed [ofs_w-1:0]  y_ofs, cb_ofs, cr_ofs;
	logic signed [prod_w-1:0] y_prod, r_cr_prod, g_cr_prod, g_cb_prod, b_cb_prod;
	logic                     s1_valid;
	logic signed [prod_w-1:0] r_sum, g_sum, b_sum;

	// floor shift by the fraction bits, then saturate
	function automatic logic [`PIX_W-1:0] clamp_pix(input logic signed [prod_w-1:0] sum);
		logic signed [prod_w-1:0] shifted;
		shifted = sum >>> 8; // arithmetic, rounds toward -inf
		if (shifted < 0)
			return '0;
		else if (shifted > 255)
			return '1;
		else
			return shifted[`PIX_W-1:0];
	endfunction

	assign y_ofs  = $signed({2'b00, ycc_pixel.y}) - luma_ofs;
	assign cb_ofs = $signed({2'b00, ycc_pixel.cb}) - chroma_ofs;
	assign cr_ofs = $signed({2'b00, ycc_pixel.cr}) - chroma_ofs;

	// ------------------------------------------------
	// stage 1: products
	// ------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_valid  <= 1'b0;
			y_prod    <= '0;
			r_cr_prod <= '0;
			g_cr_prod <= '0;
			g_cb_prod <= '0;
			b_cb_prod <= '0;
		end
		else
		begin
			s1_valid <= ycc_valid;
			if (ycc_valid)
			begin
				y_prod    <= coef_y * y_ofs;
				r_cr_prod <= coef_cr_r * cr_ofs;
				g_cr_prod <= coef_cr_g * cr_ofs;
				g_cb_prod <= coef_cb_g * cb_ofs;
				b_cb_prod <= coef_cb_b * cb_ofs;
			end
		end
	end

	assign r_sum = y_prod + r_cr_prod;
	assign g_sum = y_prod - g_cr_prod - g_cb_prod;
	assign b_sum = y_prod + b_cb_prod;

	// stage 2: sum, shift, clamp
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			rgb_valid <= 1'b0;
			rgb_pixel <= '0;
		end
		else
		begin
			rgb_valid <= s1_valid;
			if (s1_valid)
			begin
				rgb_pixel.r <= clamp_pix(r_sum);
				rgb_pixel.g <= clamp_pix(g_sum);
				rgb_pixel.b <= clamp_pix(b_sum);
			end
		end
	end

endmodule

/* color_convert/rgb_to_hsv.sv */
// rgb888 to hsv: max/min and hue difference, then saturation and 240 step hue
`timescale 1ns/1ps
`include "vision_config.svh"

module rgb_to_hsv (
	input  logic                   clk_llc,
	input  logic                   resetx,
	input  logic                   rgb_valid,
	input  video_pkg::rgb_pixel_t  rgb_pixel,
	output logic                   hsv_valid,
	output video_pkg::hsv_pixel_t  hsv_pixel
);

	localparam logic [1:0] sel_r = 2'd0;
	localparam logic [1:0] sel_g = 2'd1;
	localparam logic [1:0] sel_b = 2'd2;

	localparam logic signed [15:0] hue_sector = `HUE_SECTOR;
	localparam logic signed [15:0] hue_full   = `HUE_FULL;
	localparam logic signed [15:0] hue_g_base = `HUE_G_BASE;
	localparam logic signed [15:0] hue_b_base = `HUE_B_BASE;
	localparam logic [15:0]        full_scale = 16'd255;

	logic [`PIX_W-1:0] r, g, b;
	logic [`PIX_W-1:0] c_max, c_min;
	logic signed [`PIX_W:0] diff;  // one extra bit for sign
	logic [1:0]        max_sel;

	logic              s1_valid;
	logic [`PIX_W-1:0] max_q, delta_q;
	logic signed [`PIX_W:0] diff_q;
	logic [1:0]        sel_q;

	logic [15:0]        sat_num, sat_den, sat_full;
	logic signed [15:0] hue_num, hue_den, hue_term, hue_sum;

	assign r = rgb_pixel.r;
	assign g = rgb_pixel.g;
	assign b = rgb_pixel.b;

	// ------------------------------------------------
	// stage 1: max channel, ties go r, g, b
	// ------------------------------------------------
	always_comb
	begin
		if (r >= g && r >= b)
		begin
			max_sel = sel_r;
			c_max   = r;
			diff    = $signed({1'b0, g}) - $signed({1'b0, b});
		end
		else if (g >= b)
		begin
			max_sel = sel_g;
			c_max   = g;
			diff    = $signed({1'b0, b}) - $signed({1'b0, r});
		end
		else
		begin
			max_sel = sel_b;
			c_max   = b;
			diff    = $signed({1'b0, r}) - $signed({1'b0, g});
		end
		c_min = (r <= g && r <= b) ? r : (g <= b) ? g : b;
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_valid <= 1'b0;
			max_q    <= '0;
			delta_q  <= '0;
			diff_q   <= '0;
			sel_q    <= sel_r;
		end
		else
		begin
			s1_valid <= rgb_valid;
			if (rgb_valid)
			begin
				max_q   <= c_max;
				delta_q <= c_max - c_min;
				diff_q  <= diff;
				sel_q   <= max_sel;
			end
		end
	end

	// ------------------------------------------------
	// stage 2: saturation and hue
	// ------------------------------------------------
	always_comb
	begin
		sat_num  = delta_q * full_scale;
		sat_den  = (max_q == '0) ? 16'd1 : {8'd0, max_q};   // avoid div by zero
		sat_full = sat_num / sat_den;
		hue_num  = diff_q * hue_sector;
		hue_den  = (delta_q == '0) ? 16'sd1 : $signed({8'd0, delta_q});
		hue_term = hue_num / hue_den;   // signed, truncates toward zero
		case (sel_q)
			sel_r:
			begin
				hue_sum = hue_term + hue_full;
				if (hue_sum >= hue_full)
					hue_sum = hue_sum - hue_full; // wrap, red sits around 0
			end
			sel_g:   hue_sum = hue_term + hue_g_base;
			default: hue_sum = hue_term + hue_b_base;
		endcase
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			hsv_valid <= 1'b0;
			hsv_pixel <= '0;
		end
		else
		begin
			hsv_valid <= s1_valid;
			if (s1_valid)
			begin
				hsv_pixel.v <= max_q;
				hsv_pixel.s <= sat_full[`PIX_W-1:0]; // zero max means zero delta
				hsv_pixel.h <= hue_sum[`PIX_W-1:0];  // grey is red max, wraps to 0
			end
		end
	end

endmodule

/* verilog/color_classifier.sv */
// color classifier: hue windows and saturation/value thresholds give the color flags
`timescale 1ns/1ps
`include "vision_config.svh"

module color_classifier (
	input  logic                    clk_llc,
	input  logic                    resetx,
	input  logic                    hsv_valid,
	input  video_pkg::hsv_pixel_t   hsv_pixel,
	output logic                    class_valid,
	output video_pkg::hsv_pixel_t   class_hsv,
	output class_pkg::color_flags_t class_flags
);

	localparam logic [`PIX_W-1:0] sat_high = `SAT_HIGH;
	localparam logic [`PIX_W-1:0] sat_low  = `SAT_LOW;
	localparam logic [`PIX_W-1:0] sat_spot = `SAT_SPOT;
	localparam logic [`PIX_W-1:0] val_dark = `VAL_DARK;

	logic                    is_black;
	logic                    chroma_low, chroma_high;
	logic                    win_r, win_o, win_y, win_g, win_b;
	class_pkg::color_flags_t flags;

	// centre +/- tolerance, both ends inclusive
	function automatic logic in_window(input logic [`PIX_W-1:0] h, input int centre);
		int lo;
		int hi;
		lo = centre - `HUE_TOL;
		hi = centre + `HUE_TOL;
		return (int'(h) >= lo) && (int'(h) <= hi);
	endfunction

	// ------------------------------------------------
	// intermediate terms
	// ------------------------------------------------
	assign is_black    = (hsv_pixel.s < sat_high) && (hsv_pixel.v < val_dark);
	assign chroma_low  = !is_black && (hsv_pixel.s > sat_low);
	assign chroma_high = !is_black && (hsv_pixel.s > sat_high); // yellow only

	assign win_r = in_window(hsv_pixel.h, `HUE_RED);
	assign win_o = in_window(hsv_pixel.h, `HUE_ORANGE);
	assign win_y = in_window(hsv_pixel.h, `HUE_YELLOW);
	assign win_g = in_window(hsv_pixel.h, `HUE_GREEN);
	assign win_b = in_window(hsv_pixel.h, `HUE_BLUE);

	// flags
	always_comb
	begin
		flags.spot   = !is_black && (hsv_pixel.s > sat_spot) && (win_y || win_r);
		flags.red    = chroma_low && win_r;
		flags.orange = chroma_low && win_o;  // overlaps red/yellow edges
		flags.yellow = chroma_high && win_y;
		flags.green  = chroma_low && win_g;
		flags.blue   = chroma_low && win_b;
		flags.black  = is_black;
	end

	// ------------------------------------------------
	// output register, hsv passed along with its flags
	// ------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			class_valid <= 1'b0;
			class_hsv   <= '0;
			class_flags <= '0;
		end
		else
		begin
			class_valid <= hsv_valid;
			if (hsv_valid) // hold last result between pixels
			begin
				class_hsv   <= hsv_pixel;
				class_flags <= flags;
			end
		end
	end

endmodule

/* verilog/hsv_color_binarizer.sv */
// hsv color binarizer top: capture, rgb, hsv and classification pipeline
`timescale 1ns/1ps
`include "vision_config.svh"

module hsv_color_binarizer (
	input  logic                    clk_llc,
	input  logic                    resetx,
	input  logic                    vref,
	input  logic                    href,
	input  logic [`PIX_W-1:0]       video_byte,
	output logic                    class_valid,
	output video_pkg::hsv_pixel_t   class_hsv,
	output class_pkg::color_flags_t class_flags
);

	// ------------------------------------------------
	// stage to stage links, one valid pulse per pixel
	// ------------------------------------------------
	logic                    ycc_valid;
	video_pkg::ycbcr_pixel_t ycc_pixel;
	logic                    rgb_valid;
	video_pkg::rgb_pixel_t   rgb_pixel;
	logic                    hsv_valid;
	video_pkg::hsv_pixel_t   hsv_pixel;

	ycbcr_capture ycbcr_capture_inst (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.vref       (vref),
		.href       (href),
		.video_byte (video_byte),
		.ycc_valid  (ycc_valid),
		.ycc_pixel  (ycc_pixel)
	);

	ycbcr_to_rgb ycbcr_to_rgb_inst ( // 2 cycles
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.ycc_valid (ycc_valid),
		.ycc_pixel (ycc_pixel),
		.rgb_valid (rgb_valid),
		.rgb_pixel (rgb_pixel)
	);

	rgb_to_hsv rgb_to_hsv_inst ( // 2 cycles
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.rgb_valid (rgb_valid),
		.rgb_pixel (rgb_pixel),
		.hsv_valid (hsv_valid),
		.hsv_pixel (hsv_pixel)
	);

	color_classifier color_classifier_inst ( // 1 cycle
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.hsv_valid   (hsv_valid),
		.hsv_pixel   (hsv_pixel),
		.class_valid (class_valid),
		.class_hsv   (class_hsv),
		.class_flags (class_flags)
	);

endmodule

/* verification/tb_hsv_color_binarizer.sv */
// hsv color binarizer testbench: table of ycbcr quads with expected hsv and flags
`timescale 1ns/1ps
`include "vision_config.svh"

module tb_hsv_color_binarizer;

	localparam int n_rows     = 9;
	localparam int reset_cyc  = 5;
	localparam int clk_period = 40;
	localparam int y0_lat     = 7; // counter value seen at Y1 drive edge to Y0 result
	localparam int limit_cyc  = n_rows * 8 + 100 + reset_cyc;

	// one quad and what both of its pixels must give
	typedef struct packed {
		logic [7:0]              cb;
		logic [7:0]              y0;
		logic [7:0]              cr;
		logic [7:0]              y1;
		logic                    cut;   // href drops after Cr
		video_pkg::hsv_pixel_t   hsv0;
		class_pkg::color_flags_t flags0;
		video_pkg::hsv_pixel_t   hsv1;
		class_pkg::color_flags_t flags1;
	} quad_row_t;

	logic                    clk_llc = 1'b0;
	logic                    resetx;
	logic                    vref;
	logic                    href;
	logic [`PIX_W-1:0]       video_byte;
	logic                    class_valid;
	video_pkg::hsv_pixel_t   class_hsv;
	class_pkg::color_flags_t class_flags;

	quad_row_t               table_rows [n_rows];
	video_pkg::hsv_pixel_t   exp_hsv [$];
	class_pkg::color_flags_t exp_flags [$];
	int                      exp_cyc [$];
	int                      cyc;
	logic                    seen_any;

	hsv_color_binarizer hsv_color_binarizer_inst (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.vref        (vref),
		.href        (href),
		.video_byte  (video_byte),
		.class_valid (class_valid),
		.class_hsv   (class_hsv),
		.class_flags (class_flags)
	);

	always #(clk_period / 2) clk_llc = ~clk_llc;

	always @(posedge clk_llc)
		cyc <= cyc + 1; // edges seen so far

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("error at %0t ns: %s got %0h, expected %0h", $time, what, got, want);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// ------------------------------------------------
	// stimulus table, values worked out by hand
	// ------------------------------------------------
	function automatic void load_table();
		// grey, dark then bright
		table_rows[0] = '{8'd128, 8'd40, 8'd128, 8'd200, 1'b0,
			{8'd0, 8'd0, 8'd27}, 7'b0000001, {8'd0, 8'd0, 8'd214}, 7'b0000000};
		// magenta red, rgb 244/10/162 and 197/0/115
		table_rows[1] = '{8'd160, 8'd100, 8'd220, 8'd60, 1'b0,
			{8'd215, 8'd244, 8'd244}, 7'b1100000, {8'd217, 8'd255, 8'd197}, 7'b1100000};
		// pure red lands at hue 0, orange window
		table_rows[2] = '{8'd90, 8'd81, 8'd240, 8'd120, 1'b0,
			{8'd0, 8'd255, 8'd254}, 7'b0010000, {8'd0, 8'd211, 8'd255}, 7'b0010000};
		// yellow, hue 40 also hits orange edge
		table_rows[3] = '{8'd16, 8'd210, 8'd146, 8'd180, 1'b0,
			{8'd40, 8'd255, 8'd254}, 7'b1011000, {8'd41, 8'd255, 8'd220}, 7'b1001000};
		table_rows[4] = '{8'd54, 8'd145, 8'd34, 8'd100, 1'b0,
			{8'd80, 8'd255, 8'd255}, 7'b0000100, {8'd80, 8'd255, 8'd203}, 7'b0000100};
		table_rows[5] = '{8'd240, 8'd41, 8'd110, 8'd80, 1'b0,
			{8'd160, 8'd255, 8'd254}, 7'b0000010, {8'd160, 8'd210, 8'd255}, 7'b0000010};
		// cut short, nothing expected
		table_rows[6] = '{8'd160, 8'd100, 8'd220, 8'd0, 1'b1,
			24'd0, 7'b0000000, 24'd0, 7'b0000000};
		table_rows[7] = table_rows[1]; // recapture from Cb after blanking
		table_rows[8] = table_rows[0];
	endfunction

	// ------------------------------------------------
	// driver
	// ------------------------------------------------
	initial
	begin
		cyc        = 0;
		seen_any   = 1'b0;
		resetx     = 1'b0;
		vref       = 1'b0;
		href       = 1'b0;
		video_byte = '0;
		load_table();
		repeat (reset_cyc) @(posedge clk_llc);
		resetx <= 1'b1;
		repeat (3) @(posedge clk_llc);
		vref <= 1'b1;
		for (int i = 0; i < n_rows; i++)
		begin
			@(posedge clk_llc);
			href       <= 1'b1;
			video_byte <= table_rows[i].cb;
			@(posedge clk_llc);
			video_byte <= table_rows[i].y0;
			@(posedge clk_llc);
			video_byte <= table_rows[i].cr;
			@(posedge clk_llc);
			if (table_rows[i].cut)
			begin
				href       <= 1'b0; // partial quad
				video_byte <= '0;
			end
			else
			begin
				video_byte <= table_rows[i].y1;
				exp_hsv.push_back(table_rows[i].hsv0);
				exp_flags.push_back(table_rows[i].flags0);
				exp_cyc.push_back(cyc + y0_lat);
				exp_hsv.push_back(table_rows[i].hsv1);
				exp_flags.push_back(table_rows[i].flags1);
				exp_cyc.push_back(cyc + y0_lat + 1); // Y1 right behind Y0
			end
		end
		@(posedge clk_llc);
		href <= 1'b0;
		vref <= 1'b0;
		while (exp_hsv.size() != 0)
			@(posedge clk_llc);
		repeat (10) @(posedge clk_llc); // nothing extra may follow
		$display("RESULT: PASS");
		$finish;
	end

	// ------------------------------------------------
	// collector, samples away from the rising edge
	// ------------------------------------------------
	always @(negedge clk_llc)
	begin
		if (class_valid === 1'b1)
		begin
			if (exp_hsv.size() == 0)
			begin
				$display("class_valid pulsed with no pixel outstanding");
				$display("RESULT: FAIL");
				$fatal(1);
			end
			seen_any = 1'b1;
			check_value("valid cycle", cyc, exp_cyc[0]);
			check_value("hsv", 32'(class_hsv), 32'(exp_hsv[0]));
			check_value("flags", 32'(class_flags), 32'(exp_flags[0]));
			void'(exp_hsv.pop_front());
			void'(exp_flags.pop_front());
			void'(exp_cyc.pop_front());
		end
		else
		begin
			check_value("class_valid", 32'(class_valid), 32'd0);
			if (!seen_any)
				check_value("flags before first pixel", 32'(class_flags), 32'd0);
		end
	end

	// watchdog
	initial
	begin
		#(limit_cyc * clk_period);
		$display("timeout: expected classification outputs never arrived");
		$display("RESULT: FAIL");
		$fatal(1);
	end

endmodule

/* hsv_color_binarizer.f */
+incdir+common
common/video_pkg.sv
common/class_pkg.sv
verilog/ycbcr_capture.sv
color_convert/ycbcr_to_rgb.sv
color_convert/rgb_to_hsv.sv
verilog/color_classifier.sv
verilog/hsv_color_binarizer.sv
verification/tb_hsv_color_binarizer.sv

/* Makefile */
# Verilator build and run for hsv_color_binarizer

VERILATOR ?= verilator
TOP       ?= tb_hsv_color_binarizer
FLIST     ?= hsv_color_binarizer.f
OBJ_DIR   ?= obj_dir
BIN       ?= $(OBJ_DIR)/V$(TOP)
VFLAGS    ?= --binary

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
HDRS := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
